//--- compile.f
+incdir+hw
hw/exe_data_pkg.sv
hw/exe_ctrl_pkg.sv
hw/exe_issue.sv
hw/exe_int_alu.sv
hw/exe_mul_unit.sv
hw/exe_div_unit.sv
hw/exe_agen.sv
hw/exe_wb_select.sv
hw/exe_stage.sv
verif/exe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module exe_tb -o exe_tb_sim
./obj_dir/exe_tb_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- verif/exe_tb.sv
`include "exe_defs.svh"

module exe_tb
    import exe_data_pkg::*;
    import exe_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR  = 140;
    localparam int MAX_CYCLES = NUM_INSTR * 40 + 200;

    logic      clk = 1'b0;
    logic      rst_n_i;
    logic      flush_i;
    logic      valid_i;
    aluop_t    aluop_i;
    alu_sel_e  alusel_i;
    word_t     src1_i;
    word_t     src2_i;
    word_t     inst_i;
    logic      reg_write_en_i;
    reg_addr_t reg_write_addr_i;
    logic      addr_ok_i;
    logic      dc_valid_o;
    logic      dc_op_o;
    word_t     dc_vaddr_o;
    word_t     dc_wdata_o;
    strobe_t   dc_wstrb_o;
    logic      pause_o;
    logic      mem_valid_o;
    aluop_t    mem_aluop_o;
    logic      mem_ale_o;
    word_t     mem_addr_o;
    logic      mem_wen_o;
    reg_addr_t mem_waddr_o;
    word_t     mem_wdata_o;

    int errors    = 0;
    int checks    = 0;
    int cycle_cnt = 0;

    exe_stage dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %08h, got %08h", $time, name, exp, act);
        end
    endtask

    task automatic check_strobe(input string name, input strobe_t exp, input strobe_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %04b, got %04b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t model_alu(input aluop_t op, input word_t a, input word_t b);
        case (op)
            `ALU_ADD:  return a + b;
            `ALU_SUB:  return a - b;
            `ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `ALU_AND:  return a & b;
            `ALU_OR:   return a | b;
            `ALU_NOR:  return ~(a | b);
            `ALU_XOR:  return a ^ b;
            `ALU_SLL:  return a << b[4:0];
            `ALU_SRL:  return a >> b[4:0];
            `ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            default:   return '0;
        endcase
    endfunction

    function automatic word_t model_mul(input aluop_t op, input word_t a, input word_t b);
        longint      sa;
        longint      sb;
        logic [63:0] p;
        sa = $signed(a);
        sb = $signed(b);
        if (op == `ALU_MULHWU) begin
            p = {32'h0, a} * {32'h0, b};
        end else begin
            p = sa * sb;
        end
        return (op == `ALU_MULW) ? p[31:0] : p[63:32];
    endfunction

    function automatic word_t model_div(input aluop_t op, input word_t a, input word_t b);
        logic  sgn;
        word_t ua;
        word_t ub;
        word_t q;
        word_t r;
        sgn = (op == `ALU_DIVW) || (op == `ALU_MODW);
        if (b == '0) begin
            q = '1;
            r = a;
        end else begin
            ua = (sgn && a[31]) ? -a : a;
            ub = (sgn && b[31]) ? -b : b;
            q  = ua / ub;
            r  = ua % ub;
            if (sgn && (a[31] ^ b[31])) q = -q;
            if (sgn && a[31]) r = -r;   // remainder takes the dividend sign
        end
        return ((op == `ALU_MODW) || (op == `ALU_MODUW)) ? r : q;
    endfunction

    function automatic logic model_ale(input aluop_t op, input word_t addr);
        case (op)
            `ALU_LDH, `ALU_LDHU, `ALU_STH: return addr[0];
            `ALU_LDW, `ALU_STW:            return addr[1:0] != 2'b00;
            default:                       return 1'b0;
        endcase
    endfunction

    function automatic strobe_t model_strobe(input aluop_t op, input word_t addr);
        case (op)
            `ALU_STB: return strobe_t'(1) << addr[1:0];
            `ALU_STH: return strobe_t'(3) << {addr[1], 1'b0};
            default:  return 4'b1111;
        endcase
    endfunction

    function automatic word_t model_wdata(input aluop_t op, input word_t addr, input word_t data);
        word_t   w;
        strobe_t s;
        w = '0;
        s = model_strobe(op, addr);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                case (op)
                    `ALU_STB: w[8*i +: 8] = data[7:0];
                    `ALU_STH: w[8*i +: 8] = data[8*(i%2) +: 8];
                    default:  w[8*i +: 8] = data[8*i +: 8];
                endcase
            end
        end
        return w;
    endfunction

    function automatic word_t rand_base();
        return $urandom & 32'hffff_fffc;
    endfunction

    function automatic logic [11:0] rand_imm(input logic [1:0] off);
        logic [31:0] r;
        r = $urandom;
        return {r[9:0], off};   // low bits pick the byte offset
    endfunction

    task automatic drive_op(input aluop_t op, input alu_sel_e sel, input word_t a,
                            input word_t b, input logic [11:0] imm);
        @(negedge clk);
        valid_i          = 1'b1;
        aluop_i          = op;
        alusel_i         = sel;
        src1_i           = a;
        src2_i           = b;
        inst_i           = {10'h000, imm, 10'h000};
        reg_write_en_i   = 1'($urandom);
        reg_write_addr_i = reg_addr_t'($urandom);
        #1;
    endtask

    task automatic end_op();
        @(negedge clk);
        valid_i        = 1'b0;
        reg_write_en_i = 1'b0;
    endtask

    task automatic wait_result(input int limit, output int cycles);
        cycles = 0;
        while (!mem_valid_o && cycles < limit) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!mem_valid_o) begin
            errors++;
            $display("op %02h never raised mem_valid_o within %0d cycles", aluop_i, limit);
        end
    endtask

    task automatic check_reset_state();
        check_bit("pause_o", 1'b0, pause_o);
        check_bit("mem_valid_o", 1'b0, mem_valid_o);
        check_bit("dc_valid_o", 1'b0, dc_valid_o);
        check_bit("mul_start", 1'b0, dut.mul_start);
        check_bit("div_start", 1'b0, dut.div_start);
        check_bit("mul_done", 1'b0, dut.mul_done);
        check_bit("div_done", 1'b0, dut.div_done);
        check_bit("divider idle", 1'b1, dut.u_div.state_q == DIV_IDLE);
    endtask

    task automatic test_alu(input aluop_t op, input word_t a, input word_t b);
        drive_op(op, SEL_ARITH, a, b, 12'h000);
        check_bit("pause_o", 1'b0, pause_o);
        check_bit("mem_valid_o", 1'b1, mem_valid_o);
        check_bit("mem_wen_o", reg_write_en_i, mem_wen_o);
        check_word("mem_waddr_o", word_t'(reg_write_addr_i), word_t'(mem_waddr_o));
        check_word("mem_aluop_o", word_t'(op), word_t'(mem_aluop_o));
        check_word("mem_wdata_o", model_alu(op, a, b), mem_wdata_o);
        end_op();
    endtask

    task automatic test_mul(input aluop_t op, input word_t a, input word_t b, output word_t got);
        int cycles;
        drive_op(op, SEL_MUL, a, b, 12'h000);
        check_bit("pause_o", 1'b1, pause_o);
        wait_result(8, cycles);
        check_word("multiply cycles", 32'd2, word_t'(cycles));
        check_word("mem_wdata_o", model_mul(op, a, b), mem_wdata_o);
        got = mem_wdata_o;
        end_op();
    endtask

    task automatic mul_high_pair(input word_t a, input word_t b);
        word_t hi_s;
        word_t hi_u;
        logic  exp_diff;
        test_mul(`ALU_MULHW, a, b, hi_s);
        test_mul(`ALU_MULHWU, a, b, hi_u);
        exp_diff = model_mul(`ALU_MULHW, a, b) != model_mul(`ALU_MULHWU, a, b);
        check_bit("high words differ", exp_diff, hi_s != hi_u);
    endtask

    task automatic test_div(input aluop_t op, input word_t a, input word_t b);
        int cycles;
        drive_op(op, SEL_DIV, a, b, 12'h000);
        check_bit("pause_o", 1'b1, pause_o);
        wait_result(`EXE_DIV_STEPS + 8, cycles);
        check_word("divide cycles", (b == '0) ? 32'd2 : 32'(`EXE_DIV_STEPS + 2), word_t'(cycles));
        check_word("mem_wdata_o", model_div(op, a, b), mem_wdata_o);
        end_op();
    endtask

    task automatic test_div_flush(input word_t a, input word_t b);
        logic seen;
        drive_op(`ALU_DIVW, SEL_DIV, a, b, 12'h000);
        repeat (10) @(negedge clk);
        flush_i = 1'b1;   // mid divide
        #1;
        check_bit("mem_valid_o", 1'b0, mem_valid_o);
        @(negedge clk);
        flush_i        = 1'b0;
        valid_i        = 1'b0;
        reg_write_en_i = 1'b0;
        seen           = 1'b0;
        repeat (`EXE_DIV_STEPS + 8) begin
            @(negedge clk);
            seen = seen | dut.div_done | mem_valid_o;
        end
        check_bit("result after flush", 1'b0, seen);
        test_div(`ALU_DIVW, $urandom, $urandom % 5000 + 1);
    endtask

    task automatic test_mem(input aluop_t op, input word_t base, input logic [11:0] imm,
                            input word_t data);
        word_t addr;
        logic  ale;
        logic  store;
        addr  = base + sext12(imm);
        ale   = model_ale(op, addr);
        store = (op == `ALU_STB) || (op == `ALU_STH) || (op == `ALU_STW);
        drive_op(op, SEL_MEM, base, data, imm);
        check_bit("mem_ale_o", ale, mem_ale_o);
        check_bit("dc_valid_o", !ale, dc_valid_o);
        check_bit("pause_o", 1'b0, pause_o);
        check_bit("mem_valid_o", 1'b1, mem_valid_o);
        check_word("mem_addr_o", addr, mem_addr_o);
        check_word("mem_wdata_o", '0, mem_wdata_o);
        if (!ale) begin
            check_bit("dc_op_o", store, dc_op_o);
            check_strobe("dc_wstrb_o", model_strobe(op, addr), dc_wstrb_o);
            if (store) begin
                check_word("dc_wdata_o", model_wdata(op, addr, data), dc_wdata_o);
            end
        end
        end_op();
    endtask

    task automatic test_backpressure(input aluop_t op, input word_t base, input logic [11:0] imm,
                                     input word_t data, input int hold);
        word_t   addr;
        word_t   wdata_0;
        strobe_t wstrb_0;
        addr      = base + sext12(imm);
        addr_ok_i = 1'b0;   // cache busy
        drive_op(op, SEL_MEM, base, data, imm);
        wdata_0 = dc_wdata_o;
        wstrb_0 = dc_wstrb_o;
        check_strobe("dc_wstrb_o", model_strobe(op, addr), wstrb_0);
        for (int i = 0; i < hold; i++) begin
            if (i > 0) begin
                @(negedge clk);
                #1;
            end
            check_bit("pause_o", 1'b1, pause_o);
            check_bit("mem_valid_o", 1'b0, mem_valid_o);
            check_bit("dc_valid_o", 1'b1, dc_valid_o);
            check_word("dc_vaddr_o", addr, dc_vaddr_o);
            check_word("dc_wdata_o", wdata_0, dc_wdata_o);
            check_strobe("dc_wstrb_o", wstrb_0, dc_wstrb_o);
        end
        @(negedge clk);
        addr_ok_i = 1'b1;
        #1;
        check_bit("mem_valid_o", 1'b1, mem_valid_o);
        check_bit("pause_o", 1'b0, pause_o);
        end_op();
    endtask

    task automatic run_alu_tests();
        aluop_t ops[11];
        ops = '{`ALU_ADD, `ALU_SUB, `ALU_SLT, `ALU_SLTU, `ALU_AND, `ALU_OR,
                `ALU_NOR, `ALU_XOR, `ALU_SLL, `ALU_SRL, `ALU_SRA};
        foreach (ops[i]) begin
            test_alu(ops[i], 32'h0000_0000, 32'hffff_ffff);
            test_alu(ops[i], 32'h8000_0000, 32'hffff_ffff);
            test_alu(ops[i], 32'hffff_ffff, 32'h8000_0000);
            test_alu(ops[i], 32'h8000_0000, 32'h0000_001f);
            test_alu(ops[i], $urandom, $urandom);
            test_alu(ops[i], $urandom, $urandom);
        end
    endtask

    task automatic run_mul_tests();
        word_t a_vals[3];
        word_t b_vals[3];
        word_t a;
        word_t b;
        word_t lo;
        a_vals = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff};
        b_vals = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0001};
        for (int i = 0; i < 6; i++) begin
            if (i < 3) begin
                a = a_vals[i];
                b = b_vals[i];
            end else begin
                a = $urandom;
                b = $urandom;
            end
            test_mul(`ALU_MULW, a, b, lo);
            mul_high_pair(a, b);
        end
    endtask

    task automatic run_div_tests();
        aluop_t ops[4];
        word_t  a_vals[5];
        word_t  b_vals[5];
        ops    = '{`ALU_DIVW, `ALU_DIVUW, `ALU_MODW, `ALU_MODUW};
        a_vals = '{32'hffff_ff9c, 32'h0000_0064, 32'hffff_ff9c, 32'h8000_0000, 32'h1234_5678};
        b_vals = '{32'h0000_0007, 32'hffff_fff9, 32'hffff_fff9, 32'hffff_ffff, 32'h0000_0000};
        foreach (ops[i]) begin
            for (int j = 0; j < 5; j++) begin
                test_div(ops[i], a_vals[j], b_vals[j]);
            end
            test_div(ops[i], $urandom, $urandom);
            test_div(ops[i], $urandom, -($urandom % 1000 + 1));
        end
    endtask

    task automatic run_mem_tests();
        for (int off = 0; off < 4; off++) begin
            test_mem(`ALU_STB, rand_base(), rand_imm(off[1:0]), $urandom);
        end
        test_mem(`ALU_STH, rand_base(), rand_imm(2'd0), $urandom);
        test_mem(`ALU_STH, rand_base(), rand_imm(2'd2), $urandom);
        test_mem(`ALU_STW, rand_base(), rand_imm(2'd0), $urandom);
        test_mem(`ALU_LDB, rand_base(), rand_imm(2'd3), $urandom);
        test_mem(`ALU_LDBU, rand_base(), rand_imm(2'd1), $urandom);
        test_mem(`ALU_LDH, rand_base(), rand_imm(2'd2), $urandom);
        test_mem(`ALU_LDHU, rand_base(), rand_imm(2'd0), $urandom);
        test_mem(`ALU_LDW, rand_base(), rand_imm(2'd0), $urandom);
        // misaligned
        test_mem(`ALU_LDH, rand_base(), rand_imm(2'd1), $urandom);
        test_mem(`ALU_STH, rand_base(), rand_imm(2'd3), $urandom);
        test_mem(`ALU_LDW, rand_base(), rand_imm(2'd2), $urandom);
        test_mem(`ALU_STW, rand_base(), rand_imm(2'd1), $urandom);
    endtask

    initial begin
        void'($urandom(32'ha096_122f));
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        valid_i          = 1'b0;
        aluop_i          = '0;
        alusel_i         = SEL_ARITH;
        src1_i           = '0;
        src2_i           = '0;
        inst_i           = '0;
        reg_write_en_i   = 1'b0;
        reg_write_addr_i = '0;
        addr_ok_i        = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        #1;
        check_reset_state();
        run_alu_tests();
        run_mul_tests();
        run_div_tests();
        test_div_flush(32'hffff_1234, 32'h0000_0011);
        run_mem_tests();
        test_backpressure(`ALU_STW, rand_base(), rand_imm(2'd0), $urandom, 1 + $urandom % 8);
        test_backpressure(`ALU_LDW, rand_base(), rand_imm(2'd0), $urandom, 1 + $urandom % 8);
        test_backpressure(`ALU_STB, rand_base(), rand_imm(2'd2), $urandom, 1 + $urandom % 8);
        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_cnt);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/exe_stage.sv
module exe_stage
    import exe_data_pkg::*;
    import exe_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      valid_i,
    input  aluop_t    aluop_i,
    input  alu_sel_e  alusel_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    input  word_t     inst_i,
    input  logic      reg_write_en_i,
    input  reg_addr_t reg_write_addr_i,
    input  logic      addr_ok_i,
    output logic      dc_valid_o,
    output logic      dc_op_o,
    output word_t     dc_vaddr_o,
    output word_t     dc_wdata_o,
    output strobe_t   dc_wstrb_o,
    output logic      pause_o,
    output logic      mem_valid_o,
    output aluop_t    mem_aluop_o,
    output logic      mem_ale_o,
    output word_t     mem_addr_o,
    output logic      mem_wen_o,
    output reg_addr_t mem_waddr_o,
    output word_t     mem_wdata_o
);

    logic   mul_start;
    logic   div_start;
    logic   md_signed;
    word_t  op_a;
    word_t  op_b;
    logic   mul_done;
    dword_t product;
    logic   div_done;
    word_t  quotient;
    word_t  remainder;
    logic   div_by_zero;
    logic   mem_req;
    word_t  alu_res;

    exe_issue u_issue (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .aluop_i     (aluop_i),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .mul_done_i  (mul_done),
        .div_done_i  (div_done),
        .mem_req_i   (mem_req),
        .addr_ok_i   (addr_ok_i),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .md_signed_o (md_signed),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .pause_o     (pause_o),
        .mem_valid_o (mem_valid_o)
    );

    exe_int_alu u_int_alu (
        .aluop_i  (aluop_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .result_o (alu_res)
    );

    exe_mul_unit u_mul (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .start_i   (mul_start),
        .signed_i  (md_signed),
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .done_o    (mul_done),
        .product_o (product)
    );

    exe_div_unit u_div (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .start_i       (div_start),
        .signed_i      (md_signed),
        .dividend_i    (op_a),
        .divisor_i     (op_b),
        .done_o        (div_done),
        .quotient_o    (quotient),
        .remainder_o   (remainder),
        .div_by_zero_o (div_by_zero)
    );

    exe_agen u_agen (
        .valid_i    (valid_i),
        .flush_i    (flush_i),
        .aluop_i    (aluop_i),
        .src1_i     (src1_i),
        .src2_i     (src2_i),
        .inst_i     (inst_i),
        .mem_req_o  (mem_req),
        .dc_valid_o (dc_valid_o),
        .dc_op_o    (dc_op_o),
        .dc_vaddr_o (dc_vaddr_o),
        .dc_wdata_o (dc_wdata_o),
        .dc_wstrb_o (dc_wstrb_o),
        .ale_o      (mem_ale_o)
    );

    exe_wb_select u_wb_select (
        .alusel_i    (alusel_i),
        .aluop_i     (aluop_i),
        .alu_res_i   (alu_res),
        .product_i   (product),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .result_o    (mem_wdata_o)
    );

    assign mem_aluop_o = aluop_i;
    assign mem_addr_o  = dc_vaddr_o;
    assign mem_wen_o   = reg_write_en_i;
    assign mem_waddr_o = reg_write_addr_i;

    // zero divisor answers one cycle after the start from issue
    a_dbz_short_cut : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (div_done && div_by_zero) |-> $past(div_start) && (quotient == '1)
    );

endmodule

//--- hw/exe_wb_select.sv
`include "exe_defs.svh"

module exe_wb_select
    import exe_data_pkg::*;
    import exe_ctrl_pkg::*;
(
    input  alu_sel_e alusel_i,
    input  aluop_t   aluop_i,
    input  word_t    alu_res_i,
    input  dword_t   product_i,
    input  word_t    quotient_i,
    input  word_t    remainder_i,
    output word_t    result_o
);

    word_t mul_res;
    word_t div_res;

    always_comb begin
        case (aluop_i)
            `ALU_MULHW, `ALU_MULHWU: mul_res = product_i[2*`EXE_WORD_W-1:`EXE_WORD_W];
            default:                 mul_res = product_i[`EXE_WORD_W-1:0];   // mulw
        endcase
    end

    always_comb begin
        case (aluop_i)
            `ALU_MODW, `ALU_MODUW: div_res = remainder_i;
            default:               div_res = quotient_i;
        endcase
    end

    always_comb begin
        case (alusel_i)
            SEL_ARITH: result_o = alu_res_i;
            SEL_MUL:   result_o = mul_res;
            SEL_DIV:   result_o = div_res;
            SEL_MEM:   result_o = '0;   // load data comes later
            default:   result_o = '0;
        endcase
    end

endmodule

//--- hw/exe_agen.sv
`include "exe_defs.svh"

module exe_agen
    import exe_data_pkg::*;
    import exe_ctrl_pkg::*;
(
    input  logic    valid_i,
    input  logic    flush_i,
    input  aluop_t  aluop_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    input  word_t   inst_i,
    output logic    mem_req_o,
    output logic    dc_valid_o,
    output logic    dc_op_o,
    output word_t   dc_vaddr_o,
    output word_t   dc_wdata_o,
    output strobe_t dc_wstrb_o,
    output logic    ale_o
);

    logic [11:0] si12;
    word_t       addr;
    logic        is_mem;
    logic        misalign;

    assign si12 = inst_i[21:10];
    assign addr = src1_i + {{20{si12[11]}}, si12};

    always_comb begin
        is_mem     = 1'b0;
        dc_op_o    = 1'b0;
        misalign   = 1'b0;
        dc_wdata_o = '0;
        dc_wstrb_o = 4'b1111;   // loads read the whole word
        case (aluop_i)
            `ALU_LDB, `ALU_LDBU: begin
                is_mem = 1'b1;
            end
            `ALU_LDH, `ALU_LDHU: begin
                is_mem   = 1'b1;
                misalign = addr[0];
            end
            `ALU_LDW: begin
                is_mem   = 1'b1;
                misalign = (addr[1:0] != 2'b00);
            end
            `ALU_STB: begin
                is_mem     = 1'b1;
                dc_op_o    = 1'b1;
                dc_wdata_o = word_t'(src2_i[7:0]) << {addr[1:0], 3'b000};
                dc_wstrb_o = 4'b0001 << addr[1:0];
            end
            `ALU_STH: begin
                is_mem     = 1'b1;
                dc_op_o    = 1'b1;
                misalign   = addr[0];
                dc_wdata_o = word_t'(src2_i[15:0]) << {addr[1], 4'b0000};
                dc_wstrb_o = addr[1] ? 4'b1100 : 4'b0011;
            end
            `ALU_STW: begin
                is_mem     = 1'b1;
                dc_op_o    = 1'b1;
                misalign   = (addr[1:0] != 2'b00);
                dc_wdata_o = src2_i;
            end
            default: begin
                is_mem = 1'b0;
            end
        endcase
    end

    assign ale_o      = valid_i && misalign;
    assign mem_req_o  = valid_i && is_mem && !misalign;
    assign dc_valid_o = mem_req_o && !flush_i;
    assign dc_vaddr_o = addr;

endmodule

//--- hw/exe_div_unit.sv
`include "exe_defs.svh"

module exe_div_unit
    import exe_data_pkg::*;
    import exe_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  start_i,
    input  logic  signed_i,
    input  word_t dividend_i,
    input  word_t divisor_i,
    output logic  done_o,
    output word_t quotient_o,
    output word_t remainder_o,
    output logic  div_by_zero_o
);

    localparam int STEP_W = $clog2(`EXE_DIV_STEPS + 1);

    div_state_e          state_q;
    logic [STEP_W-1:0]   step_q;
    word_t               quo_q;
    word_t               rem_q;
    word_t               dvs_q;
    logic                q_neg_q;
    logic                r_neg_q;
    logic                dvd_neg;
    logic                dvs_neg;
    word_t               dvd_abs;
    word_t               dvs_abs;
    logic [`EXE_WORD_W:0] partial;
    logic [`EXE_WORD_W:0] diff;

    assign dvd_neg = signed_i & dividend_i[`EXE_WORD_W-1];
    assign dvs_neg = signed_i & divisor_i[`EXE_WORD_W-1];
    assign dvd_abs = dvd_neg ? -dividend_i : dividend_i;
    assign dvs_abs = dvs_neg ? -divisor_i : divisor_i;

    assign partial = {rem_q, quo_q[`EXE_WORD_W-1]};   // shift in next dividend bit
    assign diff    = partial - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= DIV_IDLE;
            step_q        <= '0;
            div_by_zero_o <= 1'b0;
        end else if (flush_i) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q       <= (divisor_i == '0) ? DIV_DONE : DIV_RUN;
                        div_by_zero_o <= (divisor_i == '0);
                        step_q        <= '0;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_W'(`EXE_DIV_STEPS - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                DIV_DONE: state_q <= DIV_IDLE;
                default:  state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            if (divisor_i == '0) begin
                quo_q   <= '1;
                rem_q   <= dividend_i;
                q_neg_q <= 1'b0;
                r_neg_q <= 1'b0;
            end else begin
                quo_q   <= dvd_abs;
                rem_q   <= '0;
                dvs_q   <= dvs_abs;
                q_neg_q <= dvd_neg ^ dvs_neg;
                r_neg_q <= dvd_neg;   // remainder follows the dividend
            end
        end else if (state_q == DIV_RUN) begin
            if (!diff[`EXE_WORD_W]) begin
                rem_q <= diff[`EXE_WORD_W-1:0];
                quo_q <= {quo_q[`EXE_WORD_W-2:0], 1'b1};
            end else begin
                rem_q <= partial[`EXE_WORD_W-1:0];   // restore
                quo_q <= {quo_q[`EXE_WORD_W-2:0], 1'b0};
            end
        end
    end

    assign done_o      = (state_q == DIV_DONE);
    assign quotient_o  = q_neg_q ? -quo_q : quo_q;
    assign remainder_o = r_neg_q ? -rem_q : rem_q;

    // nonzero divisor finishes after the full step count
    a_done_after_steps : assert property (
        @(posedge clk) disable iff (!rst_n_i || flush_i)
        (state_q == DIV_IDLE && start_i && divisor_i != '0)
            |-> ##(`EXE_DIV_STEPS + 1) done_o
    );

endmodule

//--- hw/exe_mul_unit.sv
`include "exe_defs.svh"

module exe_mul_unit
    import exe_data_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   flush_i,
    input  logic   start_i,
    input  logic   signed_i,
    input  word_t  op_a_i,
    input  word_t  op_b_i,
    output logic   done_o,
    output dword_t product_o
);

    logic signed [`EXE_WORD_W:0]     a_ext;
    logic signed [`EXE_WORD_W:0]     b_ext;
    logic signed [2*`EXE_WORD_W-1:0] prod_full;

    // extra top bit turns unsigned operands into positive signed ones
    assign a_ext = {signed_i & op_a_i[`EXE_WORD_W-1], op_a_i};
    assign b_ext = {signed_i & op_b_i[`EXE_WORD_W-1], op_b_i};

    assign prod_full = a_ext * b_ext;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i && !flush_i;   // flush drops the result
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            product_o <= prod_full;
        end
    end

endmodule

//--- hw/exe_int_alu.sv
`include "exe_defs.svh"

module exe_int_alu
    import exe_data_pkg::*;
    import exe_ctrl_pkg::*;
(
    input  aluop_t aluop_i,
    input  word_t  src1_i,
    input  word_t  src2_i,
    output word_t  result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2_i[4:0];
    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (aluop_i)
            `ALU_ADD:  result_o = src1_i + src2_i;
            `ALU_SUB:  result_o = src1_i - src2_i;
            `ALU_SLT:  result_o = word_t'(lt_signed);
            `ALU_SLTU: result_o = word_t'(lt_unsigned);
            `ALU_AND:  result_o = src1_i & src2_i;
            `ALU_OR:   result_o = src1_i | src2_i;
            `ALU_NOR:  result_o = ~(src1_i | src2_i);
            `ALU_XOR:  result_o = src1_i ^ src2_i;
            `ALU_SLL:  result_o = src1_i << shamt;
            `ALU_SRL:  result_o = src1_i >> shamt;
            `ALU_SRA:  result_o = word_t'($signed(src1_i) >>> shamt);
            default:   result_o = '0;   // not an alu op
        endcase
    end

endmodule

//--- hw/exe_issue.sv
`include "exe_defs.svh"

module exe_issue
    import exe_data_pkg::*;
    import exe_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   flush_i,
    input  logic   valid_i,
    input  aluop_t aluop_i,
    input  word_t  src1_i,
    input  word_t  src2_i,
    input  logic   mul_done_i,
    input  logic   div_done_i,
    input  logic   mem_req_i,
    input  logic   addr_ok_i,
    output logic   mul_start_o,
    output logic   div_start_o,
    output logic   md_signed_o,
    output word_t  op_a_o,
    output word_t  op_b_o,
    output logic   pause_o,
    output logic   mem_valid_o
);

    logic is_mul;
    logic is_div;
    logic is_signed;
    logic launch;
    logic busy_q;

    assign is_mul = (aluop_i == `ALU_MULW) || (aluop_i == `ALU_MULHW)
                 || (aluop_i == `ALU_MULHWU);
    assign is_div = (aluop_i == `ALU_DIVW) || (aluop_i == `ALU_DIVUW)
                 || (aluop_i == `ALU_MODW) || (aluop_i == `ALU_MODUW);
    assign is_signed = (aluop_i == `ALU_MULW) || (aluop_i == `ALU_MULHW)
                    || (aluop_i == `ALU_DIVW) || (aluop_i == `ALU_MODW);

    // one start per instruction
    assign launch = valid_i && (is_mul || is_div) && !busy_q
                 && !mul_start_o && !div_start_o && !flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            busy_q      <= 1'b0;
        end else if (flush_i) begin
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            busy_q      <= 1'b0;   // cancels the running op
        end else begin
            mul_start_o <= launch && is_mul;
            div_start_o <= launch && is_div;
            if (mul_done_i || div_done_i) begin
                busy_q <= 1'b0;
            end else if (mul_start_o || div_start_o) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            op_a_o      <= src1_i;
            op_b_o      <= src2_i;
            md_signed_o <= is_signed;
        end
    end

    assign pause_o = (valid_i && is_mul && !mul_done_i)
                  || (valid_i && is_div && !div_done_i)
                  || (mem_req_i && !addr_ok_i);   // cache not ready

    assign mem_valid_o = valid_i && !pause_o && !flush_i;

    a_no_start_when_busy : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (mul_start_o || div_start_o) |-> !busy_q
    );

endmodule

//--- hw/exe_ctrl_pkg.sv
`include "exe_defs.svh"

package exe_ctrl_pkg;

    typedef logic [`EXE_OP_W-1:0] aluop_t;

    typedef enum logic [2:0] {
        SEL_ARITH = 3'd0,
        SEL_MUL   = 3'd1,
        SEL_DIV   = 3'd2,
        SEL_MEM   = 3'd3
    } alu_sel_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

//--- hw/exe_data_pkg.sv
`include "exe_defs.svh"

package exe_data_pkg;

    typedef logic [`EXE_WORD_W-1:0] word_t;

    typedef logic [2*`EXE_WORD_W-1:0] dword_t;   // full product

    typedef logic [4:0] reg_addr_t;

    typedef logic [3:0] strobe_t;   // one bit per byte lane

endpackage

//--- hw/exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

`define EXE_WORD_W      32
`define EXE_OP_W        8
`define EXE_DIV_STEPS   32

`define ALU_ADD         8'h01
`define ALU_SUB         8'h02
`define ALU_SLT         8'h03
`define ALU_SLTU        8'h04
`define ALU_AND         8'h05
`define ALU_OR          8'h06
`define ALU_NOR         8'h07
`define ALU_XOR         8'h08
`define ALU_SLL         8'h09
`define ALU_SRL         8'h0a
`define ALU_SRA         8'h0b
`define ALU_MULW        8'h10
`define ALU_MULHW       8'h11
`define ALU_MULHWU      8'h12
`define ALU_DIVW        8'h18
`define ALU_DIVUW       8'h19
`define ALU_MODW        8'h1a
`define ALU_MODUW       8'h1b
`define ALU_LDB         8'h20
`define ALU_LDBU        8'h21
`define ALU_LDH         8'h22
`define ALU_LDHU        8'h23
`define ALU_LDW         8'h24
`define ALU_STB         8'h28
`define ALU_STH         8'h29
`define ALU_STW         8'h2a

`endif
